// File: src/memcpy_regs_consts.svh
// memcpy register block constants

`ifndef MEMCPY_REGS_CONSTS_SVH
`define MEMCPY_REGS_CONSTS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// axi-lite data and address
`define MEMCPY_DATA_W 32
`define MEMCPY_ADDR_W 32

// byte strobes per data word
`define MEMCPY_STRB_W 4

// one configuration register, low and high word
`define MEMCPY_REG_W 64

//////////////////////////////
// configuration slice map
//////////////////////////////

// control, src addr, src size, tgt addr, tgt size, rd cfg, wr cfg
`define MEMCPY_NUM_SLICES 7

// control low word sits here
`define MEMCPY_SLICE_BASE 32'h38

// low word at base, high word at base + 4
`define MEMCPY_SLICE_STRIDE 8

// returned for any unmapped read
`define MEMCPY_READ_DEFAULT 32'h5a5aa5a5

`endif

// File: src/memcpy_regs_pkg.sv
// memcpy register block types

`include "memcpy_regs_consts.svh"

package memcpy_regs_pkg;

   // fixed word addresses of the register map
   typedef enum logic [`MEMCPY_ADDR_W-1:0] {
      REG_SNAP_STATUS    = 'h00,
      REG_ACTION_TYPE    = 'h10,
      REG_ACTION_VERSION = 'h14,
      REG_SNAP_CONTEXT   = 'h20,
      REG_STATUS_L       = 'h30,
      REG_STATUS_H       = 'h34,
      REG_CONTROL_L      = 'h38,
      REG_CONTROL_H      = 'h3C,
      REG_SRC_ADDR_L     = 'h40,
      REG_SRC_ADDR_H     = 'h44,
      REG_SRC_SIZE_L     = 'h48,
      REG_SRC_SIZE_H     = 'h4C,
      REG_TGT_ADDR_L     = 'h50,
      REG_TGT_ADDR_H     = 'h54,
      REG_TGT_SIZE_L     = 'h58,
      REG_TGT_SIZE_H     = 'h5C,
      REG_RD_CFG_L       = 'h60,
      REG_RD_CFG_H       = 'h64,
      REG_WR_CFG_L       = 'h68,
      REG_WR_CFG_H       = 'h6C
   } reg_offset_e;

   // one-cycle register write strobe
   typedef struct packed {
      logic                      en;
      logic [`MEMCPY_ADDR_W-1:0] addr;
      logic [`MEMCPY_DATA_W-1:0] data;
      logic [`MEMCPY_STRB_W-1:0] strb;
   } reg_write_t;

   // copy engine configuration
   typedef struct packed {
      logic                      enable;
      logic [`MEMCPY_REG_W-1:0]  source_address;
      logic [`MEMCPY_REG_W-1:0]  target_address;
      logic [`MEMCPY_REG_W-1:0]  source_size;
      logic [`MEMCPY_REG_W-1:0]  target_size;
      logic [`MEMCPY_DATA_W-1:0] read_number;
      logic [`MEMCPY_DATA_W-1:0] read_pattern;
      logic [`MEMCPY_DATA_W-1:0] write_number;
      logic [`MEMCPY_DATA_W-1:0] write_pattern;
   } memcpy_config_t;

   // snap status as seen by the host
   typedef struct packed {
      logic [`MEMCPY_DATA_W-5:0] user;
      logic                      app_ready;
      logic                      idle;
      logic                      done;
      logic                      started;
   } snap_status_t;

   // byte-wise merge of new data into an old word
   function automatic logic [`MEMCPY_DATA_W-1:0] merge_bytes(
      input logic [`MEMCPY_DATA_W-1:0] old_word,
      input logic [`MEMCPY_DATA_W-1:0] new_word,
      input logic [`MEMCPY_STRB_W-1:0] strb
   );
      logic [`MEMCPY_DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < `MEMCPY_STRB_W; b++) begin
         if (strb[b]) begin
            result[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return result;
   endfunction

endpackage

// File: src/axi_lite_write_port.sv
// axi-lite write channel

`timescale 1ns/1ps

`include "memcpy_regs_consts.svh"

module axi_lite_write_port (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [`MEMCPY_ADDR_W-1:0] awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [`MEMCPY_DATA_W-1:0] wdata,
   input  logic [`MEMCPY_STRB_W-1:0] wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   output logic                      bvalid,
   input  logic                      bready,
   output memcpy_regs_pkg::reg_write_t wr
);

   logic [`MEMCPY_ADDR_W-1:0] write_addr;
   logic                      aw_hs;
   logic                      w_hs;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;

   //////////////////////////////
   // handshake flops
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready    <= 1'b0;
         wready     <= 1'b0;
         bvalid     <= 1'b0;
         write_addr <= '0;
      end else begin
         // address ready one cycle after awvalid, dropped after the data beat
         if (awvalid) begin
            awready <= 1'b1;
         end else if (w_hs) begin
            awready <= 1'b0;
         end

         if (aw_hs) begin
            wready     <= 1'b1;
            write_addr <= awaddr;
         end else if (wvalid) begin
            wready <= 1'b0;
         end

         // response follows the data beat
         if (w_hs) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // strobe carries latched address with live data
   assign wr.en   = w_hs;
   assign wr.addr = write_addr;
   assign wr.data = wdata;
   assign wr.strb = wstrb;

   // a response needs a data beat just before it
   a_bvalid_after_data : assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(bvalid) |-> $past(w_hs)
   );

endmodule

// File: src/config_reg_slice.sv
// 64-bit configuration register

`timescale 1ns/1ps

`include "memcpy_regs_consts.svh"

module config_reg_slice #(
   parameter logic [`MEMCPY_ADDR_W-1:0] BASE_ADDR = `MEMCPY_SLICE_BASE
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  memcpy_regs_pkg::reg_write_t wr,
   output logic [`MEMCPY_REG_W-1:0]   value
);

   import memcpy_regs_pkg::*;

   // high word sits one data word above the low word
   localparam logic [`MEMCPY_ADDR_W-1:0] HIGH_ADDR = BASE_ADDR + (`MEMCPY_DATA_W / 8);

   logic hit_low;
   logic hit_high;

   assign hit_low  = wr.en && (wr.addr == BASE_ADDR);
   assign hit_high = wr.en && (wr.addr == HIGH_ADDR);

   //////////////////////////////
   // strobed update
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         value <= '0;
      end else begin
         if (hit_low) begin
            value[`MEMCPY_DATA_W-1:0] <=
               merge_bytes(value[`MEMCPY_DATA_W-1:0], wr.data, wr.strb);
         end
         if (hit_high) begin
            value[`MEMCPY_REG_W-1:`MEMCPY_DATA_W] <=
               merge_bytes(value[`MEMCPY_REG_W-1:`MEMCPY_DATA_W], wr.data, wr.strb);
         end
      end
   end

endmodule

// File: src/snap_status_tracker.sv
// snap status and context tracking

`timescale 1ns/1ps

`include "memcpy_regs_consts.svh"

module snap_status_tracker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  memcpy_regs_pkg::reg_write_t wr,
   input  logic [2:0]                  control_low,
   input  logic                        memcpy_done,
   input  logic                        app_ready,
   output memcpy_regs_pkg::snap_status_t snap_status,
   output logic [`MEMCPY_DATA_W-1:0]   snap_context,
   output logic                        status_done
);

   import memcpy_regs_pkg::*;

   logic [`MEMCPY_DATA_W-1:0] status_reg;
   logic                      status_bit0_q;
   logic                      done_q;
   logic                      idle;
   logic                      idle_q;
   logic                      started_q;

   //////////////////////////////
   // host-written registers
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_reg   <= '0;
         snap_context <= '0;
      end else if (wr.en) begin
         if (wr.addr == REG_SNAP_STATUS) begin
            status_reg <= merge_bytes(status_reg, wr.data, wr.strb);
         end
         if (wr.addr == REG_SNAP_CONTEXT) begin
            snap_context <= merge_bytes(snap_context, wr.data, wr.strb);
         end
      end
   end

   // no run bits set in control means idle
   assign idle = ~(|control_low);

   //////////////////////////////
   // live flags
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_done   <= 1'b0;
         done_q        <= 1'b0;
         idle_q        <= 1'b0;
         status_bit0_q <= 1'b0;
         started_q     <= 1'b0;
      end else begin
         status_done   <= memcpy_done;
         done_q        <= status_done;
         idle_q        <= idle;
         status_bit0_q <= status_reg[0];

         // rising edge of host start bit
         if (!status_bit0_q && status_reg[0]) begin
            started_q <= 1'b1;
         end
         // leaving idle ends the start request
         if (idle_q && !idle) begin
            started_q <= 1'b0;
         end
      end
   end

   assign snap_status = {status_reg[`MEMCPY_DATA_W-1:4], app_ready, idle_q, done_q, started_q};

   // start flag only follows a set host start bit
   a_started_needs_bit0 : assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(started_q) |-> $past(status_reg[0])
   );

endmodule

// File: src/axi_lite_read_port.sv
// axi-lite read channel

`timescale 1ns/1ps

`include "memcpy_regs_consts.svh"

module axi_lite_read_port (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [`MEMCPY_ADDR_W-1:0]    araddr,
   input  logic                         arvalid,
   output logic                         arready,
   output logic [`MEMCPY_DATA_W-1:0]    rdata,
   output logic                         rvalid,
   input  logic                         rready,
   input  logic [`MEMCPY_NUM_SLICES-1:0][`MEMCPY_REG_W-1:0] slice_values,
   input  memcpy_regs_pkg::snap_status_t snap_status,
   input  logic [`MEMCPY_DATA_W-1:0]    snap_context,
   input  logic                         status_done,
   input  logic [`MEMCPY_DATA_W-1:0]    action_type,
   input  logic [`MEMCPY_DATA_W-1:0]    action_version
);

   import memcpy_regs_pkg::*;

   localparam int WORD_BYTES = `MEMCPY_DATA_W / 8;

   logic                      ar_hs;
   logic [`MEMCPY_ADDR_W-1:0] slice_off;
   logic [`MEMCPY_ADDR_W-1:0] slice_idx;
   logic                      slice_hit;
   logic                      sel_high;
   logic [`MEMCPY_DATA_W-1:0] rd_word;

   assign ar_hs = arvalid & arready;

   //////////////////////////////
   // address decode
   //////////////////////////////

   always_comb begin
      slice_off = araddr - `MEMCPY_SLICE_BASE;
      slice_idx = slice_off / `MEMCPY_SLICE_STRIDE;
      sel_high  = (slice_off % `MEMCPY_SLICE_STRIDE) == WORD_BYTES;
      slice_hit = (araddr >= `MEMCPY_SLICE_BASE) &&
                  (slice_idx < `MEMCPY_NUM_SLICES) &&
                  (araddr[1:0] == 2'b00);

      case (araddr)
         REG_SNAP_STATUS:    rd_word = snap_status;
         REG_ACTION_TYPE:    rd_word = action_type;
         REG_ACTION_VERSION: rd_word = action_version;
         REG_SNAP_CONTEXT:   rd_word = snap_context;
         REG_STATUS_L:       rd_word = {{(`MEMCPY_DATA_W-1){1'b0}}, status_done};
         REG_STATUS_H:       rd_word = '0;
         default: begin
            if (!slice_hit) begin
               rd_word = `MEMCPY_READ_DEFAULT;
            end else if (sel_high) begin
               rd_word = slice_values[slice_idx][`MEMCPY_REG_W-1:`MEMCPY_DATA_W];
            end else begin
               rd_word = slice_values[slice_idx][`MEMCPY_DATA_W-1:0];
            end
         end
      endcase
   end

   //////////////////////////////
   // handshake and data flops
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b1;
         rvalid  <= 1'b0;
         rdata   <= '0;
      end else begin
         // one read in flight at a time
         if (arvalid) begin
            arready <= 1'b0;
         end else if (rvalid && rready) begin
            arready <= 1'b1;
         end

         if (ar_hs) begin
            rvalid <= 1'b1;
            rdata  <= rd_word;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // back-pressure keeps read data steady
   a_rdata_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (rvalid && !rready) |=> $stable(rdata)
   );

endmodule

// File: src/memcpy_action_regs.sv
// memcpy action register block

`timescale 1ns/1ps

`include "memcpy_regs_consts.svh"

module memcpy_action_regs (
   input  logic                          clk,
   input  logic                          rst_n,
   // write channel
   input  logic [`MEMCPY_ADDR_W-1:0]     awaddr,
   input  logic                          awvalid,
   output logic                          awready,
   input  logic [`MEMCPY_DATA_W-1:0]     wdata,
   input  logic [`MEMCPY_STRB_W-1:0]     wstrb,
   input  logic                          wvalid,
   output logic                          wready,
   output logic                          bvalid,
   input  logic                          bready,
   // read channel
   input  logic [`MEMCPY_ADDR_W-1:0]     araddr,
   input  logic                          arvalid,
   output logic                          arready,
   output logic [`MEMCPY_DATA_W-1:0]     rdata,
   output logic                          rvalid,
   input  logic                          rready,
   // copy engine side
   output memcpy_regs_pkg::memcpy_config_t cfg,
   output logic [`MEMCPY_DATA_W-1:0]     snap_context,
   input  logic                          memcpy_done,
   input  logic                          app_ready,
   input  logic [`MEMCPY_DATA_W-1:0]     action_type,
   input  logic [`MEMCPY_DATA_W-1:0]     action_version
);

   import memcpy_regs_pkg::*;

   // slice positions derived from the register map
   localparam int CTRL_IDX  = (REG_CONTROL_L  - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;
   localparam int SADDR_IDX = (REG_SRC_ADDR_L - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;
   localparam int SSIZE_IDX = (REG_SRC_SIZE_L - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;
   localparam int TADDR_IDX = (REG_TGT_ADDR_L - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;
   localparam int TSIZE_IDX = (REG_TGT_SIZE_L - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;
   localparam int RDCFG_IDX = (REG_RD_CFG_L   - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;
   localparam int WRCFG_IDX = (REG_WR_CFG_L   - `MEMCPY_SLICE_BASE) / `MEMCPY_SLICE_STRIDE;

   reg_write_t                                       wr;
   snap_status_t                                     snap_status;
   logic                                             status_done;
   logic [`MEMCPY_NUM_SLICES-1:0][`MEMCPY_REG_W-1:0] slice_values;

   axi_lite_write_port u_write_port (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .wr      (wr)
   );

   //////////////////////////////
   // configuration slices
   //////////////////////////////

   for (genvar i = 0; i < `MEMCPY_NUM_SLICES; i++) begin : g_slice
      config_reg_slice #(
         .BASE_ADDR (`MEMCPY_SLICE_BASE + i * `MEMCPY_SLICE_STRIDE)
      ) u_slice (
         .clk   (clk),
         .rst_n (rst_n),
         .wr    (wr),
         .value (slice_values[i])
      );
   end

   snap_status_tracker u_tracker (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr           (wr),
      .control_low  (slice_values[CTRL_IDX][2:0]),
      .memcpy_done  (memcpy_done),
      .app_ready    (app_ready),
      .snap_status  (snap_status),
      .snap_context (snap_context),
      .status_done  (status_done)
   );

   axi_lite_read_port u_read_port (
      .clk            (clk),
      .rst_n          (rst_n),
      .araddr         (araddr),
      .arvalid        (arvalid),
      .arready        (arready),
      .rdata          (rdata),
      .rvalid         (rvalid),
      .rready         (rready),
      .slice_values   (slice_values),
      .snap_status    (snap_status),
      .snap_context   (snap_context),
      .status_done    (status_done),
      .action_type    (action_type),
      .action_version (action_version)
   );

   // counts in low words, patterns in high words
   always_comb begin
      cfg.enable         = slice_values[CTRL_IDX][0];
      cfg.source_address = slice_values[SADDR_IDX];
      cfg.target_address = slice_values[TADDR_IDX];
      cfg.source_size    = slice_values[SSIZE_IDX];
      cfg.target_size    = slice_values[TSIZE_IDX];
      cfg.read_number    = slice_values[RDCFG_IDX][`MEMCPY_DATA_W-1:0];
      cfg.read_pattern   = slice_values[RDCFG_IDX][`MEMCPY_REG_W-1:`MEMCPY_DATA_W];
      cfg.write_number   = slice_values[WRCFG_IDX][`MEMCPY_DATA_W-1:0];
      cfg.write_pattern  = slice_values[WRCFG_IDX][`MEMCPY_REG_W-1:`MEMCPY_DATA_W];
   end

endmodule

// File: verification/clock_reset_gen.sv
// testbench clock and reset

`timescale 1ns/1ps

module clock_reset_gen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release on a falling edge clear of the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: verification/memcpy_action_regs_tb.sv
// memcpy register block testbench

`timescale 1ns/1ps

`include "memcpy_regs_consts.svh"

module memcpy_action_regs_tb;

   import memcpy_regs_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int HS_LIMIT   = 16;
   localparam int WORD_COUNT = 2 * `MEMCPY_NUM_SLICES;
   localparam logic [`MEMCPY_DATA_W-1:0] TYPE_VAL    = 32'h1014_1000;
   localparam logic [`MEMCPY_DATA_W-1:0] VERSION_VAL = 32'h0000_0002;
   localparam logic                      READY_VAL   = 1'b1;

   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_SET_DONE, OP_EXPECT_CFG} op_e;

   // one step of the stimulus table
   typedef struct packed {
      op_e                       op;
      logic [`MEMCPY_ADDR_W-1:0] addr;
      logic [`MEMCPY_DATA_W-1:0] data;
      logic [`MEMCPY_STRB_W-1:0] strb;
      logic [3:0]                hold;
      logic [`MEMCPY_DATA_W-1:0] exp_word;
      logic [`MEMCPY_DATA_W-1:0] exp_context;
      memcpy_config_t            exp_cfg;
   } row_t;

   logic                      clk;
   logic                      rst_n;
   logic [`MEMCPY_ADDR_W-1:0] awaddr;
   logic                      awvalid;
   logic                      awready;
   logic [`MEMCPY_DATA_W-1:0] wdata;
   logic [`MEMCPY_STRB_W-1:0] wstrb;
   logic                      wvalid;
   logic                      wready;
   logic                      bvalid;
   logic                      bready;
   logic [`MEMCPY_ADDR_W-1:0] araddr;
   logic                      arvalid;
   logic                      arready;
   logic [`MEMCPY_DATA_W-1:0] rdata;
   logic                      rvalid;
   logic                      rready;
   memcpy_config_t            cfg;
   logic [`MEMCPY_DATA_W-1:0] snap_context;
   logic                      memcpy_done;
   logic                      app_ready;
   logic [`MEMCPY_DATA_W-1:0] action_type;
   logic [`MEMCPY_DATA_W-1:0] action_version;

   row_t                      rows[$];
   row_t                      row;
   bit                        table_ready;
   logic [`MEMCPY_DATA_W-1:0] got;
   int unsigned               seed_value;

   // reference model state with slice 0 as control
   logic [`MEMCPY_REG_W-1:0]  shadow [`MEMCPY_NUM_SLICES];
   logic [`MEMCPY_DATA_W-1:0] status_word;
   logic [`MEMCPY_DATA_W-1:0] context_word;
   logic                      done_flag;
   logic                      started_flag;

   clock_reset_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   memcpy_action_regs UUT (
      .clk (clk), .rst_n (rst_n),
      .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
      .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rvalid (rvalid), .rready (rready),
      .cfg (cfg), .snap_context (snap_context),
      .memcpy_done (memcpy_done), .app_ready (app_ready),
      .action_type (action_type), .action_version (action_version)
   );

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                 input logic [31:0] new_w,
                                                 input logic [3:0]  strb);
      logic [31:0] merged;
      merged = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) merged[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return merged;
   endfunction

   // -1 for anything that is not a slice word
   function automatic int slice_index(input logic [31:0] addr);
      logic [31:0] off;
      off = addr - `MEMCPY_SLICE_BASE;
      if (addr < `MEMCPY_SLICE_BASE || addr[1:0] != 2'b00) return -1;
      if (off / `MEMCPY_SLICE_STRIDE >= `MEMCPY_NUM_SLICES) return -1;
      return off / `MEMCPY_SLICE_STRIDE;
   endfunction

   function automatic logic is_high_word(input logic [31:0] addr);
      return ((addr - `MEMCPY_SLICE_BASE) % `MEMCPY_SLICE_STRIDE) != 0;
   endfunction

   function automatic logic [31:0] model_read(input logic [31:0] addr);
      int   idx;
      logic idle;
      idx  = slice_index(addr);
      idle = (shadow[0][2:0] == 3'b000);
      if (idx >= 0) begin
         if (is_high_word(addr)) return shadow[idx][63:32];
         return shadow[idx][31:0];
      end
      case (addr)
         REG_SNAP_STATUS:    return {status_word[31:4], READY_VAL, idle, done_flag, started_flag};
         REG_ACTION_TYPE:    return TYPE_VAL;
         REG_ACTION_VERSION: return VERSION_VAL;
         REG_SNAP_CONTEXT:   return context_word;
         REG_STATUS_L:       return {31'b0, done_flag};
         REG_STATUS_H:       return 32'h0;
         default:            return `MEMCPY_READ_DEFAULT;
      endcase
   endfunction

   function automatic memcpy_config_t model_config();
      memcpy_config_t c;
      c.enable         = shadow[0][0];
      c.source_address = shadow[1];
      c.source_size    = shadow[2];
      c.target_address = shadow[3];
      c.target_size    = shadow[4];
      c.read_number    = shadow[5][31:0];
      c.read_pattern   = shadow[5][63:32];
      c.write_number   = shadow[6][31:0];
      c.write_pattern  = shadow[6][63:32];
      return c;
   endfunction

   //////////////////////////////
   // checks
   //////////////////////////////

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_rdata(input string name, input logic [31:0] got_w,
                              input logic [31:0] exp_w);
      if (got_w !== exp_w) begin
         $display("[FAIL] %s: got %h, expected %h", name, got_w, exp_w);
         abort_run();
      end
   endtask

   task automatic check_config(input memcpy_config_t got_c, input memcpy_config_t exp_c);
      if (got_c !== exp_c) begin
         $display("[FAIL] cfg: got %h, expected %h", got_c, exp_c);
         abort_run();
      end
   endtask

   task automatic check_snap_status(input snap_status_t got_s, input snap_status_t exp_s);
      if (got_s !== exp_s) begin
         $display("[FAIL] snap_status: got %h, expected %h", got_s, exp_s);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got_b, input logic exp_b);
      if (got_b !== exp_b) begin
         $display("[FAIL] %s: got %h, expected %h", name, got_b, exp_b);
         abort_run();
      end
   endtask

   //////////////////////////////
   // bus tasks entered on a falling edge
   //////////////////////////////

   task automatic wait_one_cycle(inout int waited, input string what);
      if (waited >= HS_LIMIT) begin
         $display("no %s within %0d cycles", what, HS_LIMIT);
         abort_run();
      end else begin
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      int waited;
      waited  = 0;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wstrb   = strb;
      wvalid  = 1'b1;
      while (!awready) wait_one_cycle(waited, "write address accept");
      @(negedge clk);
      awvalid = 1'b0;
      waited  = 0;
      while (!wready) wait_one_cycle(waited, "write data accept");
      @(negedge clk);
      wvalid = 1'b0;
      waited = 0;
      while (!bvalid) wait_one_cycle(waited, "write response");
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] addr, input logic [3:0] hold,
                           output logic [31:0] data_out);
      int waited;
      waited  = 0;
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready) wait_one_cycle(waited, "read address accept");
      @(negedge clk);
      arvalid = 1'b0;
      waited  = 0;
      while (!rvalid) wait_one_cycle(waited, "read data");
      data_out = rdata;
      // rready stays low for back-pressure
      for (int c = 0; c < hold; c++) begin
         @(negedge clk);
         if (!rvalid) begin
            $display("rvalid dropped while rready was held low");
            abort_run();
         end else begin
            check_rdata("rdata under back-pressure", rdata, data_out);
         end
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   //////////////////////////////
   // stimulus table
   //////////////////////////////

   task automatic queue_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      row_t r;
      int   idx;
      logic was_idle;
      logic prev_bit0;
      r        = '0;
      r.op     = OP_WRITE;
      r.addr   = addr;
      r.data   = data;
      r.strb   = strb;
      idx      = slice_index(addr);
      was_idle = (shadow[0][2:0] == 3'b000);
      if (idx >= 0) begin
         if (is_high_word(addr))
            shadow[idx][63:32] = apply_strobes(shadow[idx][63:32], data, strb);
         else
            shadow[idx][31:0] = apply_strobes(shadow[idx][31:0], data, strb);
      end else if (addr == REG_SNAP_STATUS) begin
         prev_bit0   = status_word[0];
         status_word = apply_strobes(status_word, data, strb);
         if (!prev_bit0 && status_word[0]) started_flag = 1'b1;
      end else if (addr == REG_SNAP_CONTEXT) begin
         context_word = apply_strobes(context_word, data, strb);
      end
      // leaving idle clears started
      if (was_idle && shadow[0][2:0] != 3'b000) started_flag = 1'b0;
      rows.push_back(r);
   endtask

   task automatic append_read(input logic [31:0] addr, input logic [3:0] hold);
      row_t r;
      r          = '0;
      r.op       = OP_READ;
      r.addr     = addr;
      r.hold     = hold;
      r.exp_word = model_read(addr);
      rows.push_back(r);
   endtask

   task automatic schedule_done(input logic value);
      row_t r;
      r         = '0;
      r.op      = OP_SET_DONE;
      r.data[0] = value;
      done_flag = value;
      rows.push_back(r);
   endtask

   task automatic expect_config();
      row_t r;
      r             = '0;
      r.op          = OP_EXPECT_CFG;
      r.exp_cfg     = model_config();
      r.exp_context = context_word;
      rows.push_back(r);
   endtask

   task automatic build_table();
      foreach (shadow[i]) shadow[i] = '0;
      status_word  = '0;
      context_word = '0;
      done_flag    = 1'b0;
      started_flag = 1'b0;

      // reset values of the whole map
      append_read(REG_SNAP_STATUS, 0);
      append_read(REG_ACTION_TYPE, 0);
      append_read(REG_ACTION_VERSION, 0);
      append_read(REG_SNAP_CONTEXT, 0);
      append_read(REG_STATUS_L, 0);
      append_read(REG_STATUS_H, 0);
      for (int i = 0; i < WORD_COUNT; i++) append_read(`MEMCPY_SLICE_BASE + 4 * i, 0);
      expect_config();

      // unmapped space and context
      append_read(32'h04, 0);
      append_read(32'h70, 0);
      append_read(32'h3A, 0);
      queue_write(32'h08, $urandom, 4'hF);
      queue_write(32'h74, $urandom, 4'hF);
      expect_config();
      append_read(REG_CONTROL_L, 0);
      queue_write(REG_SNAP_CONTEXT, $urandom, 4'hF);
      expect_config();
      append_read(REG_SNAP_CONTEXT, 0);

      // live status flags
      schedule_done(1'b1);
      append_read(REG_STATUS_L, 0);
      append_read(REG_SNAP_STATUS, 0);
      queue_write(REG_SNAP_STATUS, 32'hABCD_E001, 4'hF);
      append_read(REG_SNAP_STATUS, 0);
      queue_write(REG_CONTROL_L, 32'h0000_0001, 4'hF);
      append_read(REG_SNAP_STATUS, 0);
      expect_config();

      // full-word random writes then read back
      for (int i = 0; i < WORD_COUNT; i++) queue_write(`MEMCPY_SLICE_BASE + 4 * i, $urandom, 4'hF);
      for (int i = 0; i < WORD_COUNT; i++) append_read(`MEMCPY_SLICE_BASE + 4 * i, 0);
      expect_config();

      // partial strobes
      queue_write(REG_SRC_ADDR_L, $urandom, 4'b0101);
      queue_write(REG_TGT_ADDR_H, $urandom, 4'b1000);
      queue_write(REG_WR_CFG_L, $urandom, 4'b0011);
      queue_write(REG_CONTROL_H, $urandom, 4'b0110);
      append_read(REG_SRC_ADDR_L, 0);
      append_read(REG_TGT_ADDR_H, 0);
      append_read(REG_WR_CFG_L, 0);
      append_read(REG_CONTROL_H, 0);
      expect_config();

      // reads held off by rready
      append_read(REG_SRC_SIZE_L, 6);
      append_read(REG_RD_CFG_H, 9);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      awaddr         = '0;
      awvalid        = 1'b0;
      wdata          = '0;
      wstrb          = '0;
      wvalid         = 1'b0;
      bready         = 1'b0;
      araddr         = '0;
      arvalid        = 1'b0;
      rready         = 1'b0;
      memcpy_done    = 1'b0;
      app_ready      = READY_VAL;
      action_type    = TYPE_VAL;
      action_version = VERSION_VAL;
      seed_value     = $urandom(36);
      build_table();
      table_ready = 1'b1;

      @(posedge rst_n);
      @(negedge clk);
      check_flag("arready", arready, 1'b1);
      check_flag("awready", awready, 1'b0);
      check_flag("wready", wready, 1'b0);
      check_flag("bvalid", bvalid, 1'b0);
      check_flag("rvalid", rvalid, 1'b0);
      repeat (3) @(negedge clk);

      foreach (rows[i]) begin
         row = rows[i];
         case (row.op)
            OP_WRITE: begin
               bus_write(row.addr, row.data, row.strb);
               // flags settle within 3 cycles
               repeat (3) @(negedge clk);
            end
            OP_READ: begin
               bus_read(row.addr, row.hold, got);
               if (row.addr == REG_SNAP_STATUS)
                  check_snap_status(snap_status_t'(got), snap_status_t'(row.exp_word));
               else
                  check_rdata($sformatf("rdata at %h", row.addr), got, row.exp_word);
            end
            OP_SET_DONE: begin
               memcpy_done = row.data[0];
               repeat (4) @(negedge clk);
            end
            default: begin
               check_config(cfg, row.exp_cfg);
               check_rdata("snap_context", snap_context, row.exp_context);
            end
         endcase
      end

      $display("Test completed successfully");
      $finish;
   end

   // watchdog scaled to the table length
   initial begin
      wait (table_ready);
      #((rows.size() + 1) * 40 * CLK_PERIOD);
      $display("the run did not finish before the watchdog limit");
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: flist.f
+incdir+src
src/memcpy_regs_pkg.sv
src/axi_lite_write_port.sv
src/config_reg_slice.sv
src/snap_status_tracker.sv
src/axi_lite_read_port.sv
src/memcpy_action_regs.sv
verification/clock_reset_gen.sv
verification/memcpy_action_regs_tb.sv
